//--- common/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

   ////////////////////////////////////////
   // Instruction fields
   ////////////////////////////////////////
   localparam int INSTR_W    = 32;
   localparam int OPCODE_W   = 6;
   localparam int FUNCT_W    = 6;
   localparam int OPCODE_LSB = 26;                 // Opcode sits in the top six bits

   typedef logic [INSTR_W-1:0]  instr_t;
   typedef logic [OPCODE_W-1:0] opcode_t;
   typedef logic [FUNCT_W-1:0]  funct_t;

   ////////////////////////////////////////
   // Opcodes
   ////////////////////////////////////////
   localparam opcode_t OPC_SPECIAL = 6'd0;         // R-type, decode the function field
   localparam opcode_t OPC_J       = 6'd2;
   localparam opcode_t OPC_JAL     = 6'd3;
   localparam opcode_t OPC_BEQ     = 6'd4;
   localparam opcode_t OPC_BNE     = 6'd5;
   localparam opcode_t OPC_ADDI    = 6'd8;
   localparam opcode_t OPC_SLTI    = 6'd10;
   localparam opcode_t OPC_ANDI    = 6'd12;
   localparam opcode_t OPC_ORI     = 6'd13;
   localparam opcode_t OPC_XORI    = 6'd14;
   localparam opcode_t OPC_LUI     = 6'd15;
   localparam opcode_t OPC_LB      = 6'd32;
   localparam opcode_t OPC_LH      = 6'd33;
   localparam opcode_t OPC_LW      = 6'd35;
   localparam opcode_t OPC_LBU     = 6'd36;
   localparam opcode_t OPC_LHU     = 6'd37;
   localparam opcode_t OPC_LWU     = 6'd39;
   localparam opcode_t OPC_SB      = 6'd40;
   localparam opcode_t OPC_SH      = 6'd41;
   localparam opcode_t OPC_SW      = 6'd43;

   ////////////////////////////////////////
   // Function codes
   ////////////////////////////////////////
   localparam funct_t FN_SLL  = 6'd0;
   localparam funct_t FN_SRL  = 6'd2;
   localparam funct_t FN_SRA  = 6'd3;
   localparam funct_t FN_SLLV = 6'd4;
   localparam funct_t FN_SRLV = 6'd6;
   localparam funct_t FN_SRAV = 6'd7;
   localparam funct_t FN_JR   = 6'd8;
   localparam funct_t FN_JALR = 6'd9;
   localparam funct_t FN_ADDU = 6'd33;
   localparam funct_t FN_SUBU = 6'd35;
   localparam funct_t FN_AND  = 6'd36;
   localparam funct_t FN_OR   = 6'd37;
   localparam funct_t FN_XOR  = 6'd38;
   localparam funct_t FN_NOR  = 6'd39;
   localparam funct_t FN_SLT  = 6'd42;

endpackage

`default_nettype wire

//--- common/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

   localparam int ALU_OP_W   = 2;
   localparam int ALU_CTRL_W = 4;
   localparam int MEM_SIZE_W = 2;

   typedef logic [ALU_OP_W-1:0]   alu_op_t;
   typedef logic [ALU_CTRL_W-1:0] alu_ctrl_t;
   typedef logic [MEM_SIZE_W-1:0] mem_size_t;

   ////////////////////////////////////////
   // ALU operation classes
   ////////////////////////////////////////
   localparam alu_op_t ALUOP_ADDR  = 2'd0;         // Address add for loads and stores
   localparam alu_op_t ALUOP_JUMP  = 2'd1;         // Branches and jumps
   localparam alu_op_t ALUOP_RTYPE = 2'd2;         // Look at the function field
   localparam alu_op_t ALUOP_IMM   = 2'd3;         // Immediate arithmetic and LUI

   ////////////////////////////////////////
   // ALU control codes
   ////////////////////////////////////////
   localparam alu_ctrl_t ALU_AND  = 4'd0;
   localparam alu_ctrl_t ALU_OR   = 4'd1;
   localparam alu_ctrl_t ALU_ADD  = 4'd2;
   localparam alu_ctrl_t ALU_SUB  = 4'd6;
   localparam alu_ctrl_t ALU_SLT  = 4'd7;
   localparam alu_ctrl_t ALU_LUI  = 4'd8;
   localparam alu_ctrl_t ALU_XOR  = 4'd9;
   localparam alu_ctrl_t ALU_NOR  = 4'd10;
   localparam alu_ctrl_t ALU_SLL  = 4'd11;
   localparam alu_ctrl_t ALU_SRL  = 4'd12;
   localparam alu_ctrl_t ALU_SRA  = 4'd13;
   localparam alu_ctrl_t ALU_JUMP = 4'd14;

   // Memory access size, unsigned loads share these
   localparam mem_size_t MEM_NONE = 2'd0;
   localparam mem_size_t MEM_BYTE = 2'd1;
   localparam mem_size_t MEM_HALF = 2'd2;
   localparam mem_size_t MEM_WORD = 2'd3;

endpackage

`default_nettype wire

//--- common/ctrl_word_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded control word, a plain combinational level
interface ctrl_word_if;

   logic                    reg_dst;
   logic                    reg_write;
   logic                    alu_src;
   logic                    mem_read;
   logic                    mem_write;
   logic                    mem_to_reg;
   mips_ctrl_pkg::mem_size_t mem_size;
   mips_ctrl_pkg::alu_op_t   alu_op;

   modport decoder
   (
      output reg_dst, reg_write, alu_src,
      output mem_read, mem_write, mem_to_reg,
      output mem_size, alu_op
   );

   modport stage
   (
      input reg_dst, reg_write, alu_src,
      input mem_read, mem_write, mem_to_reg,
      input mem_size, alu_op
   );

endinterface

`default_nettype wire

//--- decode/main_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module main_decoder
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;
(
   input wire instr_t   i_instruction,
   ctrl_word_if.decoder o_ctrl
);

   opcode_t opcode;
   funct_t  funct;

   assign opcode = i_instruction[OPCODE_LSB +: OPCODE_W];
   assign funct  = i_instruction[FUNCT_W-1:0];

   always_comb
   begin
      o_ctrl.reg_dst    = 1'b0;                   // Unknown codes stay all zero
      o_ctrl.reg_write  = 1'b0;
      o_ctrl.alu_src    = 1'b0;
      o_ctrl.mem_read   = 1'b0;
      o_ctrl.mem_write  = 1'b0;
      o_ctrl.mem_to_reg = 1'b0;
      o_ctrl.mem_size   = MEM_NONE;
      o_ctrl.alu_op     = ALUOP_ADDR;

      if (opcode == OPC_SPECIAL)
      begin
         case (funct)
            FN_SLL, FN_SRL, FN_SRA:
            begin
               o_ctrl.reg_dst   = 1'b1;
               o_ctrl.reg_write = 1'b1;
               o_ctrl.alu_src   = 1'b1;         // Shift amount from the instruction
               o_ctrl.alu_op    = ALUOP_RTYPE;
            end
            FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU, FN_SUBU,
            FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT:
            begin
               o_ctrl.reg_dst   = 1'b1;
               o_ctrl.reg_write = 1'b1;
               o_ctrl.alu_op    = ALUOP_RTYPE;
            end
            FN_JR:
            begin
               o_ctrl.alu_op = ALUOP_JUMP;
            end
            FN_JALR:
            begin
               o_ctrl.reg_dst   = 1'b1;          // Link into rd
               o_ctrl.reg_write = 1'b1;
               o_ctrl.alu_op    = ALUOP_JUMP;
            end
            default: ;
         endcase
      end
      else
      begin
         case (opcode)
            OPC_LB, OPC_LH, OPC_LW, OPC_LBU, OPC_LHU, OPC_LWU:
            begin
               o_ctrl.reg_write  = 1'b1;
               o_ctrl.alu_src    = 1'b1;
               o_ctrl.mem_read   = 1'b1;
               o_ctrl.mem_to_reg = 1'b1;
            end
            OPC_SB, OPC_SH, OPC_SW:
            begin
               o_ctrl.alu_src   = 1'b1;
               o_ctrl.mem_write = 1'b1;
            end
            OPC_ADDI, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_SLTI, OPC_LUI:
            begin
               o_ctrl.reg_write = 1'b1;
               o_ctrl.alu_src   = 1'b1;
               o_ctrl.alu_op    = ALUOP_IMM;
            end
            OPC_BEQ, OPC_BNE:
            begin
               o_ctrl.alu_src = 1'b1;
               o_ctrl.alu_op  = ALUOP_JUMP;
            end
            OPC_J:
            begin
               o_ctrl.alu_op = ALUOP_JUMP;
            end
            OPC_JAL:
            begin
               o_ctrl.reg_write = 1'b1;           // Link into r31
               o_ctrl.alu_op    = ALUOP_JUMP;
            end
            default: ;
         endcase

         // Access size, signed and unsigned loads alike
         case (opcode)
            OPC_LB, OPC_LBU, OPC_SB:  o_ctrl.mem_size = MEM_BYTE;
            OPC_LH, OPC_LHU, OPC_SH:  o_ctrl.mem_size = MEM_HALF;
            OPC_LW, OPC_LWU, OPC_SW:  o_ctrl.mem_size = MEM_WORD;
            default:                  o_ctrl.mem_size = MEM_NONE;
         endcase
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   always_comb
   begin
      assert final (!o_ctrl.mem_to_reg || o_ctrl.mem_read)
         else $error("main_decoder: mem_to_reg without mem_read");
   end

endmodule

`default_nettype wire

//--- decode/control_register.sv
`timescale 1ns/1ps
`default_nettype none

module control_register
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;
(
   input wire           i_clock,
   input wire           i_soft_reset,
   input wire           i_enable,
   input wire instr_t   i_instruction,
   ctrl_word_if.stage   i_ctrl,
   output logic         o_reg_dst,
   output logic         o_reg_write,
   output logic         o_alu_src,
   output logic         o_mem_read,
   output logic         o_mem_write,
   output logic         o_mem_to_reg,
   output mem_size_t    o_mem_size,
   output alu_op_t      o_alu_op,
   output opcode_t      o_opcode,
   output funct_t       o_funct
);

   always_ff @(posedge i_clock)
   begin
      if (!i_soft_reset)
      begin
         o_reg_dst    <= 1'b0;
         o_reg_write  <= 1'b0;
         o_alu_src    <= 1'b0;
         o_mem_read   <= 1'b0;
         o_mem_write  <= 1'b0;
         o_mem_to_reg <= 1'b0;
         o_mem_size   <= MEM_NONE;
         o_alu_op     <= ALUOP_ADDR;              // Gives ALU_ADD downstream
         o_opcode     <= '0;
         o_funct      <= '0;
      end
      else if (i_enable)                          // Low enable stalls the stage
      begin
         o_reg_dst    <= i_ctrl.reg_dst;
         o_reg_write  <= i_ctrl.reg_write;
         o_alu_src    <= i_ctrl.alu_src;
         o_mem_read   <= i_ctrl.mem_read;
         o_mem_write  <= i_ctrl.mem_write;
         o_mem_to_reg <= i_ctrl.mem_to_reg;
         o_mem_size   <= i_ctrl.mem_size;
         o_alu_op     <= i_ctrl.alu_op;
         o_opcode     <= i_instruction[OPCODE_LSB +: OPCODE_W];
         o_funct      <= i_instruction[FUNCT_W-1:0];
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   a_no_read_and_write : assert property (@(posedge i_clock)
      !(o_mem_read && o_mem_write))
      else $error("control_register: read and write strobes both high");

   a_hold_on_stall : assert property (@(posedge i_clock)
      (i_soft_reset && !i_enable) |=> $stable({o_reg_dst, o_reg_write, o_alu_src,
                                                o_mem_read, o_mem_write, o_mem_to_reg,
                                                o_mem_size, o_alu_op, o_opcode, o_funct}))
      else $error("control_register: outputs moved during a stall");

endmodule

`default_nettype wire

//--- src/alu_control.sv
`timescale 1ns/1ps
`default_nettype none

module alu_control
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;
(
   input wire alu_op_t  i_alu_op,
   input wire opcode_t  i_opcode,
   input wire funct_t   i_funct,
   output alu_ctrl_t    o_alu_ctrl
);

   always_comb
   begin
      case (i_alu_op)
         ALUOP_ADDR:
         begin
            o_alu_ctrl = ALU_ADD;                 // Base plus offset
         end
         ALUOP_JUMP:
         begin
            o_alu_ctrl = ALU_JUMP;
         end
         ALUOP_RTYPE:
         begin
            case (i_funct)
               FN_SLL, FN_SLLV:  o_alu_ctrl = ALU_SLL;
               FN_SRL, FN_SRLV:  o_alu_ctrl = ALU_SRL;
               FN_SRA, FN_SRAV:  o_alu_ctrl = ALU_SRA;
               FN_ADDU:          o_alu_ctrl = ALU_ADD;
               FN_SUBU:          o_alu_ctrl = ALU_SUB;
               FN_AND:           o_alu_ctrl = ALU_AND;
               FN_OR:            o_alu_ctrl = ALU_OR;
               FN_XOR:           o_alu_ctrl = ALU_XOR;
               FN_NOR:           o_alu_ctrl = ALU_NOR;
               FN_SLT:           o_alu_ctrl = ALU_SLT;
               default:          o_alu_ctrl = ALU_ADD;
            endcase
         end
         default:                                 // ALUOP_IMM, opcode picks the op
         begin
            case (i_opcode)
               OPC_ADDI:         o_alu_ctrl = ALU_ADD;
               OPC_ANDI:         o_alu_ctrl = ALU_AND;
               OPC_ORI:          o_alu_ctrl = ALU_OR;
               OPC_XORI:         o_alu_ctrl = ALU_XOR;
               OPC_SLTI:         o_alu_ctrl = ALU_SLT;
               OPC_LUI:          o_alu_ctrl = ALU_LUI;
               default:          o_alu_ctrl = ALU_ADD;
            endcase
         end
      endcase
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   always_comb
   begin
      assert final (o_alu_ctrl inside {ALU_AND, ALU_OR, ALU_ADD, ALU_SUB, ALU_SLT,
                                       ALU_LUI, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL,
                                       ALU_SRA, ALU_JUMP})
         else $error("alu_control: undefined ALU code %0d", o_alu_ctrl);
   end

endmodule

`default_nettype wire

//--- src/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;
(
   input wire           i_clock,
   input wire           i_soft_reset,
   input wire           i_enable,
   input wire instr_t   i_instruction,
   output logic         o_reg_dst,
   output logic         o_reg_write,
   output logic         o_alu_src,
   output alu_op_t      o_alu_op,
   output alu_ctrl_t    o_alu_ctrl,
   output logic         o_mem_read,
   output logic         o_mem_write,
   output logic         o_mem_to_reg,
   output mem_size_t    o_mem_size
);

   opcode_t opcode_q;                             // Fields of the registered instruction
   funct_t  funct_q;

   ctrl_word_if u_ctrl_word ();

   main_decoder u_main_decoder
   (
      .i_instruction (i_instruction),
      .o_ctrl        (u_ctrl_word)
   );

   control_register u_control_register
   (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_enable      (i_enable),
      .i_instruction (i_instruction),
      .i_ctrl        (u_ctrl_word),
      .o_reg_dst     (o_reg_dst),
      .o_reg_write   (o_reg_write),
      .o_alu_src     (o_alu_src),
      .o_mem_read    (o_mem_read),
      .o_mem_write   (o_mem_write),
      .o_mem_to_reg  (o_mem_to_reg),
      .o_mem_size    (o_mem_size),
      .o_alu_op      (o_alu_op),
      .o_opcode      (opcode_q),
      .o_funct       (funct_q)
   );

   alu_control u_alu_control
   (
      .i_alu_op   (o_alu_op),
      .i_opcode   (opcode_q),
      .i_funct    (funct_q),
      .o_alu_ctrl (o_alu_ctrl)
   );

endmodule

`default_nettype wire

//--- test/control_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit_tb
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;
();

   localparam int SEED            = 9003;
   localparam int EDGE_TIMEOUT_NS = 40;            // Ten clock periods

   // Flags {reg_dst, reg_write, alu_src, mem_read, mem_write, mem_to_reg}
   localparam logic [5:0] F_NONE   = 6'b000000;
   localparam logic [5:0] F_RTYPE  = 6'b110000;
   localparam logic [5:0] F_SHIFT  = 6'b111000;
   localparam logic [5:0] F_LOAD   = 6'b011101;
   localparam logic [5:0] F_STORE  = 6'b001010;
   localparam logic [5:0] F_IMM    = 6'b011000;
   localparam logic [5:0] F_BRANCH = 6'b001000;
   localparam logic [5:0] F_LINK   = 6'b010000;

   localparam logic [13:0] RESET_WORD = {F_NONE, MEM_NONE, ALUOP_ADDR, ALU_ADD};

   logic        i_clock;
   logic        i_soft_reset;
   logic        i_enable;
   instr_t      i_instruction;
   logic        o_reg_dst;
   logic        o_reg_write;
   logic        o_alu_src;
   alu_op_t     o_alu_op;
   alu_ctrl_t   o_alu_ctrl;
   logic        o_mem_read;
   logic        o_mem_write;
   logic        o_mem_to_reg;
   mem_size_t   o_mem_size;

   logic [13:0] actual_word;
   logic [13:0] next_word;                         // Expected decode of the driven instruction
   logic [13:0] exp_word;
   logic        check_armed;
   string       test_name;
   string       exp_name;
   string       checked_name;
   int          error_count;
   int          errors_at_start;
   int          tests_run;
   int          tests_failed;

   control_unit i_dut
   (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_enable      (i_enable),
      .i_instruction (i_instruction),
      .o_reg_dst     (o_reg_dst),
      .o_reg_write   (o_reg_write),
      .o_alu_src     (o_alu_src),
      .o_alu_op      (o_alu_op),
      .o_alu_ctrl    (o_alu_ctrl),
      .o_mem_read    (o_mem_read),
      .o_mem_write   (o_mem_write),
      .o_mem_to_reg  (o_mem_to_reg),
      .o_mem_size    (o_mem_size)
   );

   always #2 i_clock = ~i_clock;

   assign actual_word = {o_reg_dst, o_reg_write, o_alu_src, o_mem_read, o_mem_write,
                         o_mem_to_reg, o_mem_size, o_alu_op, o_alu_ctrl};

   ////////////////////////////////////////
   // Expectation and checking
   ////////////////////////////////////////
   always @(posedge i_clock)
   begin
      if (!i_soft_reset)
      begin
         exp_word <= RESET_WORD;
         exp_name <= "reset";
      end
      else if (i_enable)
      begin
         exp_word <= next_word;
         exp_name <= test_name;
      end
   end

   always @(negedge i_clock)
   begin
      checked_name = exp_name;                     // Stable across the next rising edge
   end

   a_outputs_match : assert property (@(posedge i_clock)
      check_armed |-> (actual_word == exp_word))
      else
      begin
         error_count++;
         $display("mismatch %s expected %h actual %h", checked_name,
                  $sampled(exp_word), $sampled(actual_word));
      end

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////
   task wait_falling_edges(input int count);
      int seen;
      seen = 0;
      while (seen < count)
      begin
         fork
            begin
               @(negedge i_clock);
               seen++;
            end
            begin
               #(EDGE_TIMEOUT_NS);
               $display("timeout: no falling clock edge within %0d ns", EDGE_TIMEOUT_NS);
               $display("Errors found");
               $finish;
            end
         join_any
         disable fork;
      end
   endtask

   task apply_instr(input string name, input opcode_t opc, input funct_t fn,
                    input logic [5:0] flags, input mem_size_t size, input alu_op_t op,
                    input alu_ctrl_t code);
      instr_t word;
      word = {opc, 26'($urandom())};              // Random register and immediate fields
      if (opc == OPC_SPECIAL)
         word[FUNCT_W-1:0] = fn;
      i_instruction = word;
      i_enable      = 1'b1;
      next_word     = {flags, size, op, code};
      test_name     = name;
      wait_falling_edges(1);
   endtask

   task begin_test();
      errors_at_start = error_count;
   endtask

   task end_test(input string name);
      i_enable = 1'b0;
      wait_falling_edges(1);                       // Last decode gets checked
      tests_run++;
      if (error_count == errors_at_start)
         $display("test %s passed", name);
      else
      begin
         tests_failed++;
         $display("test %s failed with %0d mismatches", name, error_count - errors_at_start);
      end
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////
   initial
   begin
      void'($urandom(SEED));
      i_clock       = 1'b0;
      i_soft_reset  = 1'b0;
      i_enable      = 1'b0;
      i_instruction = '0;
      next_word     = RESET_WORD;
      test_name     = "reset";
      check_armed   = 1'b0;
      error_count   = 0;
      tests_run     = 0;
      tests_failed  = 0;
      wait_falling_edges(3);
      i_soft_reset = 1'b1;
      check_armed  = 1'b1;

      begin_test();
      wait_falling_edges(2);                       // No enabled edge yet
      end_test("reset_values");

      begin_test();
      apply_instr("sll", OPC_SPECIAL, FN_SLL, F_SHIFT, MEM_NONE, ALUOP_RTYPE, ALU_SLL);
      apply_instr("srl", OPC_SPECIAL, FN_SRL, F_SHIFT, MEM_NONE, ALUOP_RTYPE, ALU_SRL);
      apply_instr("sra", OPC_SPECIAL, FN_SRA, F_SHIFT, MEM_NONE, ALUOP_RTYPE, ALU_SRA);
      apply_instr("sllv", OPC_SPECIAL, FN_SLLV, F_RTYPE, MEM_NONE, ALUOP_RTYPE, ALU_SLL);
      apply_instr("srlv", OPC_SPECIAL, FN_SRLV, F_RTYPE, MEM_NONE, ALUOP_RTYPE, ALU_SRL);
      apply_instr("srav", OPC_SPECIAL, FN_SRAV, F_RTYPE, MEM_NONE, ALUOP_RTYPE, ALU_SRA);
      apply_instr("addu", OPC_SPECIAL, FN_ADDU, F_RTYPE, MEM_NONE, ALUOP_RTYPE, ALU_ADD);
      apply_instr("subu", OPC_SPECIAL, FN_SUBU, F_RTYPE, MEM_NONE, ALUOP_RTYPE, ALU_SUB);
      apply_instr("and", OPC_SPECIAL, FN_AND, F_RTYPE, MEM_NONE, ALUOP_RTYPE, ALU_AND);
      apply_instr("or", OPC_SPECIAL, FN_OR, F_RTYPE, MEM_NONE, ALUOP_RTYPE, ALU_OR);
      apply_instr("xor", OPC_SPECIAL, FN_XOR, F_RTYPE, MEM_NONE, ALUOP_RTYPE, ALU_XOR);
      apply_instr("nor", OPC_SPECIAL, FN_NOR, F_RTYPE, MEM_NONE, ALUOP_RTYPE, ALU_NOR);
      apply_instr("slt", OPC_SPECIAL, FN_SLT, F_RTYPE, MEM_NONE, ALUOP_RTYPE, ALU_SLT);
      apply_instr("jr", OPC_SPECIAL, FN_JR, F_NONE, MEM_NONE, ALUOP_JUMP, ALU_JUMP);
      apply_instr("jalr", OPC_SPECIAL, FN_JALR, F_RTYPE, MEM_NONE, ALUOP_JUMP, ALU_JUMP);
      end_test("rtype");

      begin_test();
      apply_instr("lb", OPC_LB, '0, F_LOAD, MEM_BYTE, ALUOP_ADDR, ALU_ADD);
      apply_instr("lh", OPC_LH, '0, F_LOAD, MEM_HALF, ALUOP_ADDR, ALU_ADD);
      apply_instr("lw", OPC_LW, '0, F_LOAD, MEM_WORD, ALUOP_ADDR, ALU_ADD);
      apply_instr("lbu", OPC_LBU, '0, F_LOAD, MEM_BYTE, ALUOP_ADDR, ALU_ADD);
      apply_instr("lhu", OPC_LHU, '0, F_LOAD, MEM_HALF, ALUOP_ADDR, ALU_ADD);
      apply_instr("lwu", OPC_LWU, '0, F_LOAD, MEM_WORD, ALUOP_ADDR, ALU_ADD);
      apply_instr("sb", OPC_SB, '0, F_STORE, MEM_BYTE, ALUOP_ADDR, ALU_ADD);
      apply_instr("sh", OPC_SH, '0, F_STORE, MEM_HALF, ALUOP_ADDR, ALU_ADD);
      apply_instr("sw", OPC_SW, '0, F_STORE, MEM_WORD, ALUOP_ADDR, ALU_ADD);
      end_test("load_store");

      begin_test();
      apply_instr("addi", OPC_ADDI, '0, F_IMM, MEM_NONE, ALUOP_IMM, ALU_ADD);
      apply_instr("andi", OPC_ANDI, '0, F_IMM, MEM_NONE, ALUOP_IMM, ALU_AND);
      apply_instr("ori", OPC_ORI, '0, F_IMM, MEM_NONE, ALUOP_IMM, ALU_OR);
      apply_instr("xori", OPC_XORI, '0, F_IMM, MEM_NONE, ALUOP_IMM, ALU_XOR);
      apply_instr("slti", OPC_SLTI, '0, F_IMM, MEM_NONE, ALUOP_IMM, ALU_SLT);
      apply_instr("lui", OPC_LUI, '0, F_IMM, MEM_NONE, ALUOP_IMM, ALU_LUI);
      apply_instr("beq", OPC_BEQ, '0, F_BRANCH, MEM_NONE, ALUOP_JUMP, ALU_JUMP);
      apply_instr("bne", OPC_BNE, '0, F_BRANCH, MEM_NONE, ALUOP_JUMP, ALU_JUMP);
      apply_instr("j", OPC_J, '0, F_NONE, MEM_NONE, ALUOP_JUMP, ALU_JUMP);
      apply_instr("jal", OPC_JAL, '0, F_LINK, MEM_NONE, ALUOP_JUMP, ALU_JUMP);
      end_test("imm_branch_jump");

      begin_test();
      apply_instr("hold_lw", OPC_LW, '0, F_LOAD, MEM_WORD, ALUOP_ADDR, ALU_ADD);
      i_enable = 1'b0;
      repeat (6)
      begin
         i_instruction = $urandom();               // Must not reach the outputs
         wait_falling_edges(1);
      end
      apply_instr("resume_ori", OPC_ORI, '0, F_IMM, MEM_NONE, ALUOP_IMM, ALU_OR);
      end_test("stall_hold");

      begin_test();
      apply_instr("opc_1", 6'd1, '0, F_NONE, MEM_NONE, ALUOP_ADDR, ALU_ADD);
      apply_instr("opc_9", 6'd9, '0, F_NONE, MEM_NONE, ALUOP_ADDR, ALU_ADD);
      apply_instr("opc_34", 6'd34, '0, F_NONE, MEM_NONE, ALUOP_ADDR, ALU_ADD);
      apply_instr("opc_63", 6'd63, '0, F_NONE, MEM_NONE, ALUOP_ADDR, ALU_ADD);
      apply_instr("fn_1", OPC_SPECIAL, 6'd1, F_NONE, MEM_NONE, ALUOP_ADDR, ALU_ADD);
      apply_instr("fn_10", OPC_SPECIAL, 6'd10, F_NONE, MEM_NONE, ALUOP_ADDR, ALU_ADD);
      apply_instr("fn_63", OPC_SPECIAL, 6'd63, F_NONE, MEM_NONE, ALUOP_ADDR, ALU_ADD);
      end_test("unknown_codes");

      $display("tests run %0d, tests failed %0d, mismatches %0d",
               tests_run, tests_failed, error_count);
      if (error_count == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
common/mips_isa_pkg.sv
common/mips_ctrl_pkg.sv
common/ctrl_word_if.sv
decode/main_decoder.sv
decode/control_register.sv
src/alu_control.sv
src/control_unit.sv
test/control_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= control_unit_tb
RTL_TOP   ?= control_unit
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= No errors
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILE_LIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
